// ==== design/rc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receiver side definitions: stick command struct and the
// pulse timing constants used to measure RC servo pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rc_pkg;

    // sys_clk cycles per microsecond
    localparam int cycles_per_us = 4;
    // Prescaler width, safe for cycles_per_us of 1
    localparam int presc_w = $clog2(cycles_per_us + 1);

    // Pulse width counter, wide enough to pass the reject window
    localparam int width_w = 12;

    // Nominal stick travel in us
    localparam logic [width_w-1:0] pulse_min_us = 12'd1000;
    localparam logic [width_w-1:0] pulse_max_us = 12'd2000;

    // Anything outside this window is treated as noise
    localparam logic [width_w-1:0] pulse_reject_lo_us = 12'd900;
    localparam logic [width_w-1:0] pulse_reject_hi_us = 12'd2100;

    // 1000 us of travel gives commands 0 to 250
    localparam int us_per_step = 4;

    // Throttle silence before failsafe
    localparam int failsafe_us = 60000;
    localparam int fs_w = $clog2(failsafe_us + 1);

    // Roll, pitch and yaw rest value
    localparam logic [7:0] stick_center = 8'd125;

    // Stick commands, 0 to 250 each
    typedef struct packed {
        logic [7:0] throttle;
        logic [7:0] roll;
        logic [7:0] pitch;
        logic [7:0] yaw;
    } rc_channels_t;

endpackage

// ==== design/motor_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Motor side definitions: rate struct, mixer limits and the
// ESC frame timing shared by the timer and the generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package motor_pkg;

    // Largest rate a motor may be given
    localparam logic [7:0] rate_max = 8'd250;

    // Motors stay off below this throttle command
    localparam logic [7:0] arm_throttle = 8'd10;

    // ESC frame period in us
    localparam int frame_us = 20000;
    // Microsecond counter inside one frame
    localparam int frame_cnt_w = $clog2(frame_us);

    // Width of signed mixer sums
    // throttle plus three offsets spans -375 to 625
    localparam int mix_w = 11;

    // Motor rates, X frame numbering
    typedef struct packed {
        logic [7:0] m1;
        logic [7:0] m2;
        logic [7:0] m3;
        logic [7:0] m4;
    } motor_rates_t;

endpackage

// ==== design/frame_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timebase: one-cycle microsecond tick and a frame start
// strobe every ESC frame, both shared by the whole core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frame_timer (
    input  logic sys_clk,
    input  logic resetn,
    output logic us_tick,
    output logic frame_start
);

    logic [rc_pkg::presc_w-1:0]        presc_cnt;
    logic [motor_pkg::frame_cnt_w-1:0] us_cnt;

    // Tick on last cycle of each microsecond
    assign us_tick = (presc_cnt == rc_pkg::presc_w'(rc_pkg::cycles_per_us - 1));

    // Last us of the frame, so first strobe lands a full frame after reset
    assign frame_start = us_tick &&
                         (us_cnt == motor_pkg::frame_cnt_w'(motor_pkg::frame_us - 1));

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            presc_cnt <= '0;
            us_cnt    <= '0;
        end else begin
            if (us_tick) begin
                presc_cnt <= '0;
                // Wrap the frame counter on the strobe
                if (frame_start) begin
                    us_cnt <= '0;
                end else begin
                    us_cnt <= us_cnt + 1'b1;
                end
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/rc_pulse_capture.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receiver front end: measures four RC pulses in us, drops
// noise, scales to 0..250 and applies the throttle failsafe
// rc_pwm bit 0 throttle, 1 roll, 2 pitch, 3 yaw
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rc_pulse_capture (
    input  logic                 sys_clk,
    input  logic                 resetn,
    input  logic                 us_tick,
    input  logic [3:0]           rc_pwm,
    output rc_pkg::rc_channels_t sticks,
    output logic                 sticks_update
);

    // Two flop synchronizer plus one flop for edge detect
    logic [3:0] sync_a;
    logic [3:0] sync_b;
    logic [3:0] sync_c;
    logic [3:0] fall;
    logic [3:0] fall_pend;
    logic [3:0] ready;
    logic [3:0] accept;

    logic [rc_pkg::width_w-1:0] width_cnt [4];
    logic [7:0]                 cmd_q [4];
    logic [7:0]                 cmd_d [4];

    logic [rc_pkg::fs_w-1:0] silence_cnt;
    logic                    failsafe_hit;
    logic                    changed;

    // Clamp to nominal travel, drop offset, scale to steps
    function automatic logic [7:0] scale_width(input logic [rc_pkg::width_w-1:0] w);
        logic [rc_pkg::width_w-1:0] clamped;
        logic [rc_pkg::width_w-1:0] offset;
        if (w < rc_pkg::pulse_min_us) begin
            clamped = rc_pkg::pulse_min_us;
        end else if (w > rc_pkg::pulse_max_us) begin
            clamped = rc_pkg::pulse_max_us;
        end else begin
            clamped = w;
        end
        offset = clamped - rc_pkg::pulse_min_us;
        return 8'(offset / rc_pkg::us_per_step);
    endfunction

    assign fall = sync_c & ~sync_b;

    always_comb begin
        for (int ch = 0; ch < 4; ch++) begin
            // Edge seen now or waiting for the next tick
            ready[ch]  = fall[ch] | fall_pend[ch];
            accept[ch] = us_tick && ready[ch] &&
                         (width_cnt[ch] >= rc_pkg::pulse_reject_lo_us) &&
                         (width_cnt[ch] <= rc_pkg::pulse_reject_hi_us);
            cmd_d[ch]  = accept[ch] ? scale_width(width_cnt[ch]) : cmd_q[ch];
        end
        // Throttle silent too long
        failsafe_hit = us_tick && !accept[0] &&
                       (silence_cnt == rc_pkg::fs_w'(rc_pkg::failsafe_us - 1));
        if (failsafe_hit) begin
            cmd_d[0] = '0;
        end
        changed = 1'b0;
        for (int ch = 0; ch < 4; ch++) begin
            changed = changed | (cmd_d[ch] != cmd_q[ch]);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            sync_a        <= '0;
            sync_b        <= '0;
            sync_c        <= '0;
            fall_pend     <= '0;
            silence_cnt   <= '0;
            sticks_update <= 1'b0;
            for (int ch = 0; ch < 4; ch++) begin
                width_cnt[ch] <= '0;
                cmd_q[ch]     <= (ch == 0) ? 8'd0 : rc_pkg::stick_center;
            end
        end else begin
            sync_a <= rc_pwm;
            sync_b <= sync_a;
            sync_c <= sync_b;
            for (int ch = 0; ch < 4; ch++) begin
                if (us_tick && ready[ch]) begin
                    // Width consumed, start over for next pulse
                    width_cnt[ch] <= '0;
                    fall_pend[ch] <= 1'b0;
                end else begin
                    if (fall[ch]) begin
                        fall_pend[ch] <= 1'b1;
                    end
                    // Count high time, saturate on a stuck line
                    if (us_tick && sync_b[ch] && (width_cnt[ch] != '1)) begin
                        width_cnt[ch] <= width_cnt[ch] + 1'b1;
                    end
                end
                cmd_q[ch] <= cmd_d[ch];
            end
            // Silence timer restarts on every good throttle pulse
            if (us_tick) begin
                if (accept[0]) begin
                    silence_cnt <= '0;
                end else if (silence_cnt != rc_pkg::fs_w'(rc_pkg::failsafe_us)) begin
                    silence_cnt <= silence_cnt + 1'b1;
                end
            end
            sticks_update <= changed;
        end
    end

    assign sticks = '{throttle: cmd_q[0], roll: cmd_q[1], pitch: cmd_q[2], yaw: cmd_q[3]};

endmodule

// ==== design/quad_mixer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// X frame motor mixer: stick commands in, four clamped and
// arm gated motor rates out, updated on each stick strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module quad_mixer (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  rc_pkg::rc_channels_t    sticks,
    input  logic                    sticks_update,
    output motor_pkg::motor_rates_t rates
);

    logic signed [motor_pkg::mix_w-1:0] thr;
    logic signed [motor_pkg::mix_w-1:0] roll_off;
    logic signed [motor_pkg::mix_w-1:0] pitch_off;
    logic signed [motor_pkg::mix_w-1:0] yaw_off;
    logic signed [motor_pkg::mix_w-1:0] sum [4];
    logic                               armed;
    motor_pkg::motor_rates_t            rates_d;

    // Unsigned command to signed mixer word
    function automatic logic signed [motor_pkg::mix_w-1:0] widen(input logic [7:0] v);
        return signed'({{(motor_pkg::mix_w - 8){1'b0}}, v});
    endfunction

    // Limit a sum to 0 .. rate_max
    function automatic logic [7:0] clamp_rate(input logic signed [motor_pkg::mix_w-1:0] s);
        logic signed [motor_pkg::mix_w-1:0] upper;
        upper = widen(motor_pkg::rate_max);
        if (s < 0) begin
            return 8'd0;
        end else if (s > upper) begin
            return motor_pkg::rate_max;
        end else begin
            return s[7:0];
        end
    endfunction

    always_comb begin
        // Offsets around stick center, -125 .. 125
        thr       = widen(sticks.throttle);
        roll_off  = widen(sticks.roll) - widen(rc_pkg::stick_center);
        pitch_off = widen(sticks.pitch) - widen(rc_pkg::stick_center);
        yaw_off   = widen(sticks.yaw) - widen(rc_pkg::stick_center);

        // Props: m1 front right, m2 front left, m3 rear left, m4 rear right
        sum[0] = thr - roll_off + pitch_off + yaw_off;
        sum[1] = thr + roll_off + pitch_off - yaw_off;
        sum[2] = thr + roll_off - pitch_off + yaw_off;
        sum[3] = thr - roll_off - pitch_off - yaw_off;

        armed = (sticks.throttle >= motor_pkg::arm_throttle);

        // Disarmed means every motor off
        rates_d.m1 = armed ? clamp_rate(sum[0]) : 8'd0;
        rates_d.m2 = armed ? clamp_rate(sum[1]) : 8'd0;
        rates_d.m3 = armed ? clamp_rate(sum[2]) : 8'd0;
        rates_d.m4 = armed ? clamp_rate(sum[3]) : 8'd0;
    end

    // One cycle after the stick strobe
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            rates <= '0;
        end else if (sticks_update) begin
            rates <= rates_d;
        end
    end

endmodule

// ==== design/esc_pwm_generator.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ESC pulse output: latches motor rates at frame start and
// drives four 1000..2000 us pulses from one shared counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module esc_pwm_generator (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  logic                    us_tick,
    input  logic                    frame_start,
    input  motor_pkg::motor_rates_t rates,
    output logic [3:0]              esc_pwm
);

    logic [rc_pkg::width_w-1:0] us_cnt;
    logic [rc_pkg::width_w-1:0] us_next;
    logic [rc_pkg::width_w-1:0] width_q [4];
    logic [7:0]                 rate_arr [4];

    assign rate_arr[0] = rates.m1;
    assign rate_arr[1] = rates.m2;
    assign rate_arr[2] = rates.m3;
    assign rate_arr[3] = rates.m4;

    // Elapsed us after this tick
    assign us_next = us_cnt + 1'b1;

    // Widths held for the whole frame
    always_ff @(posedge sys_clk) begin
        if (frame_start) begin
            for (int m = 0; m < 4; m++) begin
                width_q[m] <= rc_pkg::pulse_min_us +
                              rc_pkg::width_w'(rc_pkg::us_per_step) *
                              rc_pkg::width_w'(rate_arr[m]);
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            us_cnt  <= '0;
            esc_pwm <= '0;
        end else if (frame_start) begin
            // All pulses rise together
            us_cnt  <= '0;
            esc_pwm <= '1;
        end else if (us_tick) begin
            // Saturate, frame start always clears it first
            if (us_cnt != '1) begin
                us_cnt <= us_next;
            end
            for (int m = 0; m < 4; m++) begin
                esc_pwm[m] <= esc_pwm[m] && (us_next < width_q[m]);
            end
        end
    end

endmodule

// ==== design/flight_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flight command path top: RC pulses in, ESC pulses out
// Timer, receiver capture, mixer and ESC generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module flight_core (
    input  logic       sys_clk,
    input  logic       resetn,
    input  logic [3:0] rc_pwm,
    output logic [3:0] esc_pwm
);

    // Timebase
    logic us_tick;
    logic frame_start;

    // Receiver to mixer
    rc_pkg::rc_channels_t sticks;
    logic                 sticks_update;

    // Mixer to ESC outputs
    motor_pkg::motor_rates_t rates;

    frame_timer u_timer (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .us_tick     (us_tick),
        .frame_start (frame_start)
    );

    rc_pulse_capture u_capture (
        .sys_clk       (sys_clk),
        .resetn        (resetn),
        .us_tick       (us_tick),
        .rc_pwm        (rc_pwm),
        .sticks        (sticks),
        .sticks_update (sticks_update)
    );

    quad_mixer u_mixer (
        .sys_clk       (sys_clk),
        .resetn        (resetn),
        .sticks        (sticks),
        .sticks_update (sticks_update),
        .rates         (rates)
    );

    esc_pwm_generator u_esc (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .us_tick     (us_tick),
        .frame_start (frame_start),
        .rates       (rates),
        .esc_pwm     (esc_pwm)
    );

endmodule

// ==== verification/flight_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ESC pulse checker: times each esc_pwm high pulse and, in
// the checked frame, compares it with the reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module flight_checker (
    input logic             sys_clk,
    input logic             resetn,
    input logic [3:0]       esc_pwm,
    input logic             check_window,
    input logic [3:0][11:0] stick_us,
    input logic             failsafe
);

    int         err_count = 0;
    int         check_count = 0;
    int         high_cycles [4];
    logic [3:0] esc_q;

    // Expected ESC width in us for one motor, from receiver widths
    function automatic int expected_width_us(input logic [3:0][11:0] w, input logic fs,
                                             input int motor);
        int cmd [4];
        int us;
        int sum;
        for (int ch = 0; ch < 4; ch++) begin
            us = int'(w[ch]);
            // Clamp to nominal stick travel
            if (us < int'(rc_pkg::pulse_min_us)) begin
                us = int'(rc_pkg::pulse_min_us);
            end else if (us > int'(rc_pkg::pulse_max_us)) begin
                us = int'(rc_pkg::pulse_max_us);
            end
            cmd[ch] = (us - int'(rc_pkg::pulse_min_us)) / rc_pkg::us_per_step;
            // Offsets around center for roll, pitch, yaw
            if (ch != 0) begin
                cmd[ch] = cmd[ch] - int'(rc_pkg::stick_center);
            end
        end
        if (fs) begin
            cmd[0] = 0;
        end
        // Disarmed, all motors at minimum
        if (cmd[0] < int'(motor_pkg::arm_throttle)) begin
            return int'(rc_pkg::pulse_min_us);
        end
        case (motor)
            0: sum = cmd[0] - cmd[1] + cmd[2] + cmd[3];
            1: sum = cmd[0] + cmd[1] + cmd[2] - cmd[3];
            2: sum = cmd[0] + cmd[1] - cmd[2] + cmd[3];
            default: sum = cmd[0] - cmd[1] - cmd[2] - cmd[3];
        endcase
        if (sum < 0) begin
            sum = 0;
        end else if (sum > int'(motor_pkg::rate_max)) begin
            sum = int'(motor_pkg::rate_max);
        end
        return int'(rc_pkg::pulse_min_us) + rc_pkg::us_per_step * sum;
    endfunction

    // Sample on the falling clock edge, outputs settled
    always @(negedge sys_clk) begin
        int got;
        int want;
        if (!resetn) begin
            esc_q = '0;
            for (int m = 0; m < 4; m++) begin
                high_cycles[m] = 0;
            end
        end else begin
            for (int m = 0; m < 4; m++) begin
                if (esc_pwm[m]) begin
                    high_cycles[m]++;
                end else if (esc_q[m]) begin
                    // Pulse just ended
                    got = high_cycles[m] / rc_pkg::cycles_per_us;
                    high_cycles[m] = 0;
                    if (check_window) begin
                        want = expected_width_us(stick_us, failsafe, m);
                        check_count++;
                        if (got != want) begin
                            err_count++;
                            $display("[FAIL] esc_pwm[%0d] (m%0d) expected 0x%0h us, actual 0x%0h us",
                                     m, m + 1, want, got);
                        end
                    end
                end
            end
            esc_q = esc_pwm;
        end
    end

endmodule

// ==== verification/flight_core_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flight core testbench: drives RC pulses per frame, runs
// the test sequence and reports the verdict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module flight_core_tb;

    localparam int num_tests = 12;
    // Three frames per test plus start-up margin
    localparam int timeout_cycles = (num_tests * 3 + 2) * motor_pkg::frame_us *
                                    rc_pkg::cycles_per_us;

    logic             sys_clk;
    logic             resetn;
    logic [3:0]       rc_pwm;
    logic [3:0]       esc_pwm;
    logic             check_window;
    logic             failsafe_exp;
    // Last accepted width per channel as the DUT should hold it
    logic [3:0][11:0] model_us;
    int               pass_count;
    int               fail_count;
    int               test_num;
    int               cycle_count;

    flight_core u_dut (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .rc_pwm  (rc_pwm),
        .esc_pwm (esc_pwm)
    );

    flight_checker u_check (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .esc_pwm      (esc_pwm),
        .check_window (check_window),
        .stick_us     (model_us),
        .failsafe     (failsafe_exp)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge sys_clk);
            cycle_count++;
        end
        $display("timeout: tests did not finish");
        $display("** FAIL **");
        $finish;
    end

    // Channel order throttle, roll, pitch, yaw
    function automatic logic [3:0][11:0] stick_widths(input int thr, input int roll,
                                                      input int pitch, input int yaw);
        return {12'(yaw), 12'(pitch), 12'(roll), 12'(thr)};
    endfunction

    function automatic int rand_us();
        return $urandom_range(2000, 1000);
    endfunction

    task automatic wait_frame_start();
        @(negedge sys_clk);
        while (!u_dut.frame_start) begin
            @(negedge sys_clk);
        end
    endtask

    // All channel pulses rise together
    // Zero width means no pulse on that channel
    task automatic drive_frame(input logic [3:0][11:0] w);
        int longest;
        longest = 0;
        for (int ch = 0; ch < 4; ch++) begin
            if (int'(w[ch]) > longest) begin
                longest = int'(w[ch]);
            end
            rc_pwm[ch] = (w[ch] != 12'd0);
        end
        for (int cyc = 1; cyc <= longest * rc_pkg::cycles_per_us; cyc++) begin
            @(negedge sys_clk);
            for (int ch = 0; ch < 4; ch++) begin
                if (cyc == int'(w[ch]) * rc_pkg::cycles_per_us) begin
                    rc_pwm[ch] = 1'b0;
                end
            end
        end
    endtask

    task automatic run_test(input string name, input logic [3:0][11:0] w, input logic fs);
        int err0;
        int chk0;
        // Out of window pulses leave the held value alone
        for (int ch = 0; ch < 4; ch++) begin
            if (w[ch] >= 12'd900 && w[ch] <= 12'd2100) begin
                model_us[ch] = w[ch];
            end
        end
        failsafe_exp = fs;
        err0 = u_check.err_count;
        chk0 = u_check.check_count;
        for (int f = 0; f < 3; f++) begin
            wait_frame_start();
            check_window = (f == 2);
            drive_frame(w);
        end
        while (esc_pwm != 4'b0) begin
            @(negedge sys_clk);
        end
        // Let the checker take the last falling edge first
        @(negedge sys_clk);
        check_window = 1'b0;
        test_num++;
        if (u_check.check_count - chk0 != 4) begin
            $display("test %0d %s: only %0d of 4 ESC pulses ended in the checked frame",
                     test_num, name, u_check.check_count - chk0);
            fail_count++;
        end else if (u_check.err_count != err0) begin
            $display("test %0d %s: wrong ESC width", test_num, name);
            fail_count++;
        end else begin
            $display("test %0d %s: ok", test_num, name);
            pass_count++;
        end
    endtask

    initial begin
        void'($urandom(22));
        resetn       = 1'b0;
        rc_pwm       = 4'b0;
        check_window = 1'b0;
        failsafe_exp = 1'b0;
        model_us     = stick_widths(1000, 1500, 1500, 1500);
        pass_count   = 0;
        fail_count   = 0;
        test_num     = 0;
        repeat (16) @(negedge sys_clk);
        resetn = 1'b1;

        run_test("throttle 1200 centered", stick_widths(1200, 1500, 1500, 1500), 1'b0);
        run_test("throttle 1500 centered", stick_widths(1500, 1500, 1500, 1500), 1'b0);
        run_test("throttle 2000 centered", stick_widths(2000, 1500, 1500, 1500), 1'b0);
        run_test("throttle below arming",
                 stick_widths(1030, rand_us(), rand_us(), rand_us()), 1'b0);
        repeat (3) begin
            run_test("random roll pitch yaw",
                     stick_widths(1500, rand_us(), rand_us(), rand_us()), 1'b0);
        end
        // m2 sums far above rate_max, the other three sum below zero
        run_test("extreme sticks", stick_widths(1400, 2000, 2000, 1000), 1'b0);
        run_test("throttle 2050 clamped", stick_widths(2050, 1500, 1500, 1500), 1'b0);
        run_test("roll 850 ignored", stick_widths(2050, 850, 1500, 1500), 1'b0);
        // Throttle silent but failsafe not yet due at the checked frame
        run_test("throttle lost", stick_widths(0, 1500, 1500, 1500), 1'b0);
        run_test("throttle failsafe", stick_widths(0, 1500, 1500, 1500), 1'b1);

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/rc_pkg.sv
design/motor_pkg.sv
design/frame_timer.sv
design/rc_pulse_capture.sv
design/quad_mixer.sv
design/esc_pwm_generator.sv
design/flight_core.sv
verification/flight_checker.sv
verification/flight_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the flight core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module flight_core_tb -o sim_flight_core
./obj_dir/sim_flight_core > sim.log
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
